/* verilog/pipePkg.sv */
//////////////////////////////
// Types shared by the four-stage integer core
// Only the R, I and S instruction formats are described
//////////////////////////////
package pipePkg;

  localparam int xLen = 32;                // Integer data width

  typedef logic [4:0] regAddrT;            // Register number, x0 is hard zero

  // Major opcodes handled by Decode
  typedef enum logic [6:0] {
    opR     = 7'b0110011,                  // ADD SUB AND OR XOR
    opImm   = 7'b0010011,                  // ADDI
    opLoad  = 7'b0000011,                  // LW
    opStore = 7'b0100011                   // SW
  } opcodeT;

  typedef enum logic [2:0] {
    aluAdd = 3'd0,
    aluSub = 3'd1,
    aluAnd = 3'd2,
    aluOr  = 3'd3,
    aluXor = 3'd4
  } aluOpT;

  // Execute operand source, encoded as in the hazard unit muxes
  typedef enum logic [1:0] {
    fwdNone = 2'b00,                       // Register file value from Decode
    fwdW    = 2'b01,                       // Writeback result
    fwdM    = 2'b10                        // Memory-stage ALU result
  } fwdSelT;

  //////////////////////////////
  // Instruction word views
  //////////////////////////////
  typedef struct packed {
    logic [6:0] funct7;
    regAddrT    rs2;
    regAddrT    rs1;
    logic [2:0] funct3;
    regAddrT    rd;
    logic [6:0] opcode;
  } rTypeT;

  typedef struct packed {
    logic [11:0] imm12;                    // Sign-extended in Decode
    regAddrT     rs1;
    logic [2:0]  funct3;
    regAddrT     rd;
    logic [6:0]  opcode;
  } iTypeT;

  typedef struct packed {
    logic [6:0] immHi;                     // Offset bits 11:5
    regAddrT    rs2;
    regAddrT    rs1;
    logic [2:0] funct3;
    logic [4:0] immLo;                     // Offset bits 4:0
    logic [6:0] opcode;
  } sTypeT;

  typedef union packed {
    rTypeT r;
    iTypeT i;
    sTypeT s;
  } instrT;

endpackage

/* verilog/hazardIf.sv */
//////////////////////////////
// Datapath to hazard unit bundle
// clk and rstN feed the hazard unit checks only
//////////////////////////////
interface hazardIf import pipePkg::*; (
  input logic clk,
  input logic rstN
);

  regAddrT rs1D, rs2D;                     // Decode sources
  regAddrT rs1E, rs2E, rdE;                // Execute sources and destination
  regAddrT rdM, rdW;                       // Later destinations
  logic    memReadE;                       // Load sitting in Execute
  logic    regWriteM, regWriteW;           // Result will reach the register file
  fwdSelT  forwardAE, forwardBE;           // Execute operand selects
  logic    stallD;                         // Hold Decode one cycle

  // Datapath side
  modport dp (
    output rs1D, rs2D, rs1E, rs2E, rdE, rdM, rdW,
    output memReadE, regWriteM, regWriteW,
    input  forwardAE, forwardBE, stallD
  );

  // Hazard unit side
  modport hz (
    input  clk, rstN,
    input  rs1D, rs2D, rs1E, rs2E, rdE, rdM, rdW,
    input  memReadE, regWriteM, regWriteW,
    output forwardAE, forwardBE, stallD
  );

endinterface

/* verilog/forward.sv */
//////////////////////////////
// Purely combinational forwarding and load-use hazard unit
// rs2 is compared for every format so ADDI and LW may stall needlessly
//////////////////////////////
module forward import pipePkg::*; (
  hazardIf.hz hz
);

  logic matchDE;                           // Decode source waits on Execute result

  // Newest producer wins so Memory beats Writeback
  always_comb begin
    hz.forwardAE = fwdNone;
    hz.forwardBE = fwdNone;
    if (hz.rs1E != '0) begin
      if (hz.regWriteM && (hz.rs1E == hz.rdM)) begin
        hz.forwardAE = fwdM;
      end else if (hz.regWriteW && (hz.rs1E == hz.rdW)) begin
        hz.forwardAE = fwdW;
      end
    end
    if (hz.rs2E != '0) begin
      if (hz.regWriteM && (hz.rs2E == hz.rdM)) begin
        hz.forwardBE = fwdM;
      end else if (hz.regWriteW && (hz.rs2E == hz.rdW)) begin
        hz.forwardBE = fwdW;
      end
    end
  end

  // Load data exists only at the end of Memory and comes too late for the next Execute
  assign matchDE   = ((hz.rs1D == hz.rdE) || (hz.rs2D == hz.rdE)) && (hz.rdE != '0);
  assign hz.stallD = hz.memReadE && matchDE;

  //////////////////////////////
  // Checks
  //////////////////////////////
  // The bubble loaded during a stall clears the load from Execute
  stallOneCycle: assert property (@(posedge hz.clk) disable iff (!hz.rstN)
    hz.stallD |=> !hz.stallD);

  // x0 source never picks up a forwarded value
  noForwardFromZero: assert property (@(posedge hz.clk) disable iff (!hz.rstN)
    (hz.rs1E == '0) |-> (hz.forwardAE == fwdNone));

endmodule

/* verilog/regFile.sv */
//////////////////////////////
// 31 x 32 register file, x0 hard wired to zero
// Same-cycle read of the written register returns wd
//////////////////////////////
module regFile import pipePkg::*; (
  input  logic            clk,
  input  logic            rstN,
  input  regAddrT         ra1,
  input  regAddrT         ra2,
  output logic [xLen-1:0] rd1,
  output logic [xLen-1:0] rd2,
  input  logic            we,
  input  regAddrT         wa,
  input  logic [xLen-1:0] wd
);

  logic [xLen-1:0] regs [31:1];            // No storage for x0

  // Write at the edge, x0 writes dropped
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (wa != '0)) begin
      regs[wa] <= wd;
    end
  end

  // Write-through bypass covers the three-apart dependency
  always_comb begin
    if (ra1 == '0)                 rd1 = '0;
    else if (we && (wa == ra1))    rd1 = wd;
    else                           rd1 = regs[ra1];
    if (ra2 == '0)                 rd2 = '0;
    else if (we && (wa == ra2))    rd2 = wd;
    else                           rd2 = regs[ra2];
  end

endmodule

/* verilog/aluExec.sv */
//////////////////////////////
// Execute ALU, wrap-around arithmetic
//////////////////////////////
module aluExec import pipePkg::*; (
  input  logic [xLen-1:0] a,
  input  logic [xLen-1:0] b,
  input  aluOpT           op,
  output logic [xLen-1:0] y
);

  logic [xLen-1:0] sum;                    // Shared adder, b inverted for SUB
  logic [xLen-1:0] bInv;
  logic            isSub;

  assign isSub = (op == aluSub);
  assign bInv  = isSub ? ~b : b;
  assign sum   = a + bInv + {{(xLen-1){1'b0}}, isSub}; // Carry out discarded

  always_comb begin
    case (op)
      aluAdd,
      aluSub:  y = sum;
      aluAnd:  y = a & b;
      aluOr:   y = a | b;
      aluXor:  y = a ^ b;
      default: y = sum;                    // Unused codes fall back to add
    endcase
  end

endmodule

/* verilog/dataMem.sv */
//////////////////////////////
// Word data memory, memWords must be a power of two
// Address wraps modulo memWords, contents undefined until written
//////////////////////////////
module dataMem import pipePkg::*; #(
  parameter int memWords = 64
) (
  input  logic            clk,
  input  logic [xLen-1:0] addr,
  input  logic [xLen-1:0] wdata,
  input  logic            we,
  output logic [xLen-1:0] rdata
);

  localparam int idxW = $clog2(memWords);

  logic [xLen-1:0] mem [memWords];
  logic [idxW-1:0] idx;                    // Word index, byte offset dropped

  assign idx = addr[idxW+1:2];

  // Write lands at the edge that ends Memory
  always_ff @(posedge clk) begin
    if (we) begin
      mem[idx] <= wdata;
    end
  end

  assign rdata = mem[idx];                 // Combinational load path

  // Only whole-word stores are supported
  storeAligned: assert property (@(posedge clk) we |-> (addr[1:0] == 2'b00));

endmodule

/* verilog/pipeDatapath.sv */
//////////////////////////////
// Decode, Execute, Memory and Writeback of the integer core
// Source must hold instr while stall is high
//////////////////////////////
module pipeDatapath import pipePkg::*; #(
  parameter int memWords = 64
) (
  input  logic            clk,
  input  logic            rstN,
  input  logic            instrValid,
  input  instrT           instr,
  output logic            stall,
  output logic            wbValid,
  output regAddrT         wbRd,
  output logic [xLen-1:0] wbData,
  hazardIf.dp             hz
);

  // Decode signals
  opcodeT          opD;
  logic            legalD, regWriteD, memReadD, memWriteD, useImmD;
  aluOpT           aluOpD;
  logic [xLen-1:0] immD, rd1D, rd2D;
  logic            acceptD;

  // Execute stage
  logic            regWriteE, memReadE, memWriteE, useImmE;
  aluOpT           aluOpE;
  regAddrT         rs1E, rs2E, rdE;
  logic [xLen-1:0] rd1E, rd2E, immE;
  logic [xLen-1:0] srcAE, srcBE, bE, aluE;

  // Memory and Writeback stages
  logic            regWriteM, memReadM, memWriteM;
  regAddrT         rdM, rdW;
  logic [xLen-1:0] aluM, storeDataM, loadM, resultM;
  logic            regWriteW;
  logic [xLen-1:0] resultW;

  //////////////////////////////
  // Decode
  //////////////////////////////
  assign opD = opcodeT'(instr.r.opcode);

  always_comb begin
    legalD    = 1'b1;
    regWriteD = 1'b0;
    memReadD  = 1'b0;
    memWriteD = 1'b0;
    useImmD   = 1'b1;
    aluOpD    = aluAdd;
    immD      = {{(xLen-12){instr.i.imm12[11]}}, instr.i.imm12}; // I form by default
    case (opD)
      opR, opImm: begin
        regWriteD = 1'b1;
        useImmD   = (opD == opImm);
        case (instr.r.funct3)
          3'b000:  aluOpD = (opD == opR && instr.r.funct7[5]) ? aluSub : aluAdd;
          3'b111:  aluOpD = aluAnd;
          3'b110:  aluOpD = aluOr;
          3'b100:  aluOpD = aluXor;
          default: legalD = 1'b0;          // Shifts and compares not built
        endcase
      end
      opLoad: begin
        regWriteD = 1'b1;
        memReadD  = 1'b1;
      end
      opStore: begin
        memWriteD = 1'b1;
        immD      = {{(xLen-12){instr.s.immHi[6]}}, instr.s.immHi, instr.s.immLo};
      end
      default: legalD = 1'b0;              // Unknown opcode becomes a bubble
    endcase
  end

  // Idle strobe presents x0 so it never matches a load destination
  assign hz.rs1D = instrValid ? instr.r.rs1 : '0;
  assign hz.rs2D = instrValid ? instr.r.rs2 : '0;
  assign stall   = hz.stallD;
  assign acceptD = instrValid && !hz.stallD && legalD;

  regFile rf0 (
    .clk  (clk),
    .rstN (rstN),
    .ra1  (instr.r.rs1),
    .ra2  (instr.r.rs2),
    .rd1  (rd1D),
    .rd2  (rd2D),
    .we   (regWriteW),
    .wa   (rdW),
    .wd   (resultW)
  );

  //////////////////////////////
  // Execute
  //////////////////////////////
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      regWriteE <= 1'b0;
      memReadE  <= 1'b0;
      memWriteE <= 1'b0;
    end else begin
      regWriteE <= acceptD && regWriteD;   // Stall or idle strobe loads a bubble
      memReadE  <= acceptD && memReadD;
      memWriteE <= acceptD && memWriteD;
    end
  end

  always_ff @(posedge clk) begin
    useImmE <= useImmD;
    aluOpE  <= aluOpD;
    rs1E    <= instr.r.rs1;
    rs2E    <= instr.r.rs2;
    rdE     <= instr.r.rd;
    rd1E    <= rd1D;
    rd2E    <= rd2D;
    immE    <= immD;
  end

  always_comb begin
    case (hz.forwardAE)
      fwdM:    srcAE = aluM;
      fwdW:    srcAE = resultW;
      default: srcAE = rd1E;
    endcase
    case (hz.forwardBE)
      fwdM:    srcBE = aluM;
      fwdW:    srcBE = resultW;
      default: srcBE = rd2E;
    endcase
  end

  assign bE = useImmE ? immE : srcBE;      // srcBE doubles as store data

  aluExec alu0 (
    .a  (srcAE),
    .b  (bE),
    .op (aluOpE),
    .y  (aluE)
  );

  assign hz.rs1E     = rs1E;
  assign hz.rs2E     = rs2E;
  assign hz.rdE      = rdE;
  assign hz.memReadE = memReadE;

  //////////////////////////////
  // Memory and Writeback
  //////////////////////////////
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      regWriteM <= 1'b0;
      memReadM  <= 1'b0;
      memWriteM <= 1'b0;
      regWriteW <= 1'b0;
      wbValid   <= 1'b0;
    end else begin
      regWriteM <= regWriteE;
      memReadM  <= memReadE;
      memWriteM <= memWriteE;
      regWriteW <= regWriteM;
      wbValid   <= regWriteW;              // Pulses as the register file is written
    end
  end

  always_ff @(posedge clk) begin
    aluM       <= aluE;
    storeDataM <= srcBE;
    rdM        <= rdE;
    resultW    <= resultM;
    rdW        <= rdM;
    wbRd       <= rdW;
    wbData     <= resultW;
  end

  dataMem #(.memWords(memWords)) mem0 (
    .clk   (clk),
    .addr  (aluM),
    .wdata (storeDataM),
    .we    (memWriteM),
    .rdata (loadM)
  );

  assign resultM      = memReadM ? loadM : aluM;
  assign hz.rdM       = rdM;
  assign hz.rdW       = rdW;
  assign hz.regWriteM = regWriteM;
  assign hz.regWriteW = regWriteW;

  // First accepted instruction needs three more edges to reach the outputs
  noEarlyWriteback: assert property (@(posedge clk) $rose(rstN) |-> !wbValid [*4]);

endmodule

/* verilog/pipeTop.sv */
//////////////////////////////
// Integer core top, plain ports
// memWords must be a power of two
//////////////////////////////
module pipeTop import pipePkg::*; #(
  parameter int memWords = 64
) (
  input  logic            clk,
  input  logic            rstN,
  input  logic            instrValid,      // Issue strobe
  input  instrT           instr,
  output logic            stall,           // Back-pressure, source holds instr
  output logic            wbValid,
  output regAddrT         wbRd,
  output logic [xLen-1:0] wbData
);

  // Single bundle between datapath and hazard unit
  hazardIf hzBus0 (
    .clk  (clk),
    .rstN (rstN)
  );

  pipeDatapath #(.memWords(memWords)) dp0 (
    .clk        (clk),
    .rstN       (rstN),
    .instrValid (instrValid),
    .instr      (instr),
    .stall      (stall),
    .wbValid    (wbValid),
    .wbRd       (wbRd),
    .wbData     (wbData),
    .hz         (hzBus0.dp)
  );

  forward hz0 (
    .hz (hzBus0.hz)
  );

endmodule

/* verification/pipeTopTb.sv */
//////////////////////////////
// Table-driven testbench for pipeTop
// Expected results are hand-computed from the RV32I rules
//////////////////////////////
module pipeTopTb;

  localparam int numEntries = 31;
  localparam int cycleLimit = 4 * numEntries + 30;   // Run limit in clock cycles

  // RV32I encodings
  localparam logic [6:0] opcR     = 7'b0110011;
  localparam logic [6:0] opcImm   = 7'b0010011;
  localparam logic [6:0] opcLoad  = 7'b0000011;
  localparam logic [6:0] opcStore = 7'b0100011;
  localparam logic [2:0] f3Add    = 3'b000;          // ADD, SUB, ADDI
  localparam logic [2:0] f3And    = 3'b111;
  localparam logic [2:0] f3Or     = 3'b110;
  localparam logic [2:0] f3Xor    = 3'b100;
  localparam logic [2:0] f3Word   = 3'b010;          // LW, SW
  localparam logic [6:0] f7Base   = 7'b0000000;
  localparam logic [6:0] f7Sub    = 7'b0100000;

  logic        clk;
  logic        rstN;
  logic        instrValid;
  logic [31:0] instr;
  logic        stall;
  logic        wbValid;
  logic [4:0]  wbRd;
  logic [31:0] wbData;

  logic [31:0] progInstr [numEntries];               // Issue order
  logic [4:0]  expRd     [numEntries];               // Stores leave no entry here
  logic [31:0] expData   [numEntries];
  int          stepCount;
  int          expCount;

  int   wbSeen;                                      // Writeback pulses so far
  int   valueErrors;
  int   countErrors;
  int   otherErrors;
  int   cycles;
  int   idx;
  logic stallSeen;

  pipeTop #(.memWords(64)) dut0 (
    .clk        (clk),
    .rstN       (rstN),
    .instrValid (instrValid),
    .instr      (instr),
    .stall      (stall),
    .wbValid    (wbValid),
    .wbRd       (wbRd),
    .wbData     (wbData)
  );

  //////////////////////////////
  // Instruction encoders
  //////////////////////////////
  function automatic logic [31:0] rOp(input logic [6:0] f7, input logic [2:0] f3,
                                      input logic [4:0] rd, input logic [4:0] rs1,
                                      input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, opcR};
  endfunction

  function automatic logic [31:0] addi(input logic [4:0] rd, input logic [4:0] rs1,
                                       input logic [11:0] imm);
    return {imm, rs1, f3Add, rd, opcImm};
  endfunction

  function automatic logic [31:0] lw(input logic [4:0] rd, input logic [4:0] rs1,
                                     input logic [11:0] imm);
    return {imm, rs1, f3Word, rd, opcLoad};
  endfunction

  function automatic logic [31:0] sw(input logic [4:0] rs2, input logic [4:0] rs1,
                                     input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, f3Word, imm[4:0], opcStore};  // S form splits the offset
  endfunction

  // Append one table row, writebacks queued in the same order
  task automatic setStep(input logic [31:0] word, input logic [4:0] rd,
                         input logic [31:0] data, input logic isStore);
    progInstr[stepCount] = word;
    stepCount++;
    if (!isStore) begin
      expRd[expCount]   = rd;
      expData[expCount] = data;
      expCount++;
    end
  endtask

  task automatic loadProgram();
    // Independent ADDI, then each R-type op
    setStep(addi(5'd1, 5'd0, 12'd100), 5'd1, 32'h0000_0064, 1'b0);
    setStep(addi(5'd2, 5'd0, 12'hFF9), 5'd2, 32'hFFFF_FFF9, 1'b0);  // -7
    setStep(addi(5'd3, 5'd0, 12'h7FF), 5'd3, 32'h0000_07FF, 1'b0);
    setStep(rOp(f7Base, f3Add, 5'd4, 5'd1, 5'd2), 5'd4, 32'h0000_005D, 1'b0);
    setStep(rOp(f7Sub, f3Add, 5'd5, 5'd2, 5'd1), 5'd5, 32'hFFFF_FF95, 1'b0);
    setStep(rOp(f7Base, f3And, 5'd6, 5'd2, 5'd3), 5'd6, 32'h0000_07F9, 1'b0);
    setStep(rOp(f7Base, f3Or, 5'd7, 5'd1, 5'd2), 5'd7, 32'hFFFF_FFFD, 1'b0);
    setStep(rOp(f7Base, f3Xor, 5'd8, 5'd1, 5'd3), 5'd8, 32'h0000_079B, 1'b0);
    setStep(addi(5'd9, 5'd0, 12'hFFF), 5'd9, 32'hFFFF_FFFF, 1'b0);
    setStep(addi(5'd10, 5'd9, 12'd2), 5'd10, 32'h0000_0001, 1'b0);  // Wraps past zero
    setStep(rOp(f7Sub, f3Add, 5'd11, 5'd0, 5'd1), 5'd11, 32'hFFFF_FF9C, 1'b0);
    // Forwarding distances 1, 2 and 3
    setStep(addi(5'd12, 5'd0, 12'd5), 5'd12, 32'h0000_0005, 1'b0);
    setStep(rOp(f7Base, f3Add, 5'd13, 5'd12, 5'd12), 5'd13, 32'h0000_000A, 1'b0);
    setStep(rOp(f7Base, f3Add, 5'd14, 5'd12, 5'd13), 5'd14, 32'h0000_000F, 1'b0);
    setStep(rOp(f7Base, f3Add, 5'd15, 5'd12, 5'd0), 5'd15, 32'h0000_0005, 1'b0);
    // Memory and Writeback both hold x16, newer value must win
    setStep(addi(5'd16, 5'd0, 12'd1), 5'd16, 32'h0000_0001, 1'b0);
    setStep(addi(5'd16, 5'd16, 12'd2), 5'd16, 32'h0000_0003, 1'b0);
    setStep(rOp(f7Base, f3Add, 5'd17, 5'd16, 5'd16), 5'd17, 32'h0000_0006, 1'b0);
    // Store then load back
    setStep(addi(5'd18, 5'd0, 12'h123), 5'd18, 32'h0000_0123, 1'b0);
    setStep(rOp(f7Base, f3Xor, 5'd19, 5'd18, 5'd5), 5'd19, 32'hFFFF_FEB6, 1'b0);
    setStep(sw(5'd19, 5'd0, 12'd8), 5'd0, 32'h0, 1'b1);
    setStep(lw(5'd20, 5'd0, 12'd8), 5'd20, 32'hFFFF_FEB6, 1'b0);
    setStep(rOp(f7Base, f3Add, 5'd21, 5'd20, 5'd1), 5'd21, 32'hFFFF_FF1A, 1'b0); // Load-use
    setStep(sw(5'd3, 5'd0, 12'd20), 5'd0, 32'h0, 1'b1);
    setStep(lw(5'd22, 5'd0, 12'd20), 5'd22, 32'h0000_07FF, 1'b0);
    setStep(rOp(f7Sub, f3Add, 5'd23, 5'd1, 5'd22), 5'd23, 32'hFFFF_F865, 1'b0); // Via rs2
    // x0 as destination and as source
    setStep(addi(5'd0, 5'd0, 12'd55), 5'd0, 32'h0000_0037, 1'b0);
    setStep(rOp(f7Base, f3Add, 5'd24, 5'd0, 5'd1), 5'd24, 32'h0000_0064, 1'b0);
    setStep(rOp(f7Base, f3Add, 5'd0, 5'd1, 5'd1), 5'd0, 32'h0000_00C8, 1'b0);
    setStep(addi(5'd25, 5'd0, 12'd3), 5'd25, 32'h0000_0003, 1'b0);
    setStep(rOp(f7Base, f3Or, 5'd26, 5'd0, 5'd0), 5'd26, 32'h0000_0000, 1'b0);
  endtask

  task automatic reportErrorCounts();
    $display("Error counts: %0d wrong values, %0d missing or extra writebacks, %0d other",
             valueErrors, countErrors, otherErrors);
  endtask

  //////////////////////////////
  // Clock, stimulus, checks
  //////////////////////////////
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial begin
    rstN        = 1'b0;
    instrValid  = 1'b0;
    instr       = '0;
    stepCount   = 0;
    expCount    = 0;
    wbSeen      = 0;
    valueErrors = 0;
    countErrors = 0;
    otherErrors = 0;
    stallSeen   = 1'b0;
    loadProgram();
    repeat (10) @(posedge clk);
    rstN <= 1'b1;
    @(posedge clk);
    idx = 0;
    while (idx < numEntries) begin
      instrValid <= 1'b1;
      instr      <= progInstr[idx];
      @(negedge clk);                                // stall settled mid-cycle
      if (stall) begin
        stallSeen = 1'b1;                            // Same entry offered again
      end else begin
        idx++;
      end
      @(posedge clk);
    end
    instrValid <= 1'b0;
    instr      <= '0;
    while (wbSeen < expCount) @(negedge clk);        // Watchdog bounds this wait
    repeat (8) @(negedge clk);                       // Window for stray pulses
    assert (wbSeen <= expCount) else begin
      countErrors += wbSeen - expCount;
      $display("Saw %0d writebacks but only %0d were expected", wbSeen, expCount);
    end
    assert (stallSeen) else begin
      otherErrors++;
      $display("The stall output never went high during the load-use cases");
    end
    reportErrorCounts();
    if (valueErrors + countErrors + otherErrors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // In-order writeback checker, sampled away from the clock edge
  always @(negedge clk) begin
    if (rstN && wbValid) begin
      if (wbSeen < expCount) begin
        assert (wbRd === expRd[wbSeen]) else begin
          valueErrors++;
          $display("Fail %0t wbRd expected %0d got %0d", $time, expRd[wbSeen], wbRd);
        end
        assert (wbData === expData[wbSeen]) else begin
          valueErrors++;
          $display("Fail %0t wbData expected %h got %h", $time, expData[wbSeen], wbData);
        end
      end
      wbSeen++;
    end
  end

  // Watchdog
  initial begin
    cycles = 0;
    while (cycles < cycleLimit) begin
      @(posedge clk);
      cycles++;
    end
    if (wbSeen < expCount) begin
      countErrors += expCount - wbSeen;
    end
    otherErrors++;
    $display("Timeout after %0d cycles with %0d of %0d writebacks seen",
             cycleLimit, wbSeen, expCount);
    reportErrorCounts();
    $display("Done: errors found");
    $finish;
  end

endmodule

/* all.f */
verilog/pipePkg.sv
verilog/hazardIf.sv
verilog/forward.sv
verilog/regFile.sv
verilog/aluExec.sv
verilog/dataMem.sv
verilog/pipeDatapath.sv
verilog/pipeTop.sv
verification/pipeTopTb.sv

/* Bender.yml */
package:
  name: pipe_core

sources:
  - verilog/pipePkg.sv
  - verilog/hazardIf.sv
  - verilog/forward.sv
  - verilog/regFile.sv
  - verilog/aluExec.sv
  - verilog/dataMem.sv
  - verilog/pipeDatapath.sv
  - verilog/pipeTop.sv
  - target: test
    files:
      - verification/pipeTopTb.sv
